//--- logic/isa_pkg.sv
package isa_pkg;

    // data path and pc width
    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // opcode fields, major group down to minor group
    localparam int op_a_hi = 31;
    localparam int op_a_lo = 26;
    localparam int op_b_hi = 25;
    localparam int op_b_lo = 22;
    localparam int op_c_hi = 21;
    localparam int op_c_lo = 20;
    localparam int op_d_hi = 19;
    localparam int op_d_lo = 15;

    // register fields, low bit of each
    localparam int rd_lo = 0;
    localparam int rj_lo = 5;
    localparam int rk_lo = 10;

    // bl links through r1
    localparam reg_idx_t ra_index = 5'd1;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_H, MEM_LD_W, MEM_LD_BU,
        MEM_LD_HU, MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JIRL, BR_B, BR_BL, BR_BEQ,
        BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    // how the immediate is cut out of the instruction
    typedef enum logic [2:0] {
        IMM_NONE, IMM_SI12, IMM_UI12, IMM_SI16_SH2,
        IMM_SI26_SH2, IMM_UI20_HI, IMM_UI5
    } imm_kind_e;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // where each execute operand comes from
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_PC
    } src_sel_e;

    typedef enum logic [1:0] {
        EXCP_NONE,
        EXCP_SYS,
        EXCP_BRK,
        EXCP_INE
    } excp_e;

    // decoded bundle handed to execute
    typedef struct packed {
        alu_op_e  alu_op;
        mem_op_e  mem_op;
        br_op_e   br_op;
        src_sel_e src1_sel;
        src_sel_e src2_sel;
        logic     wreg_en;
        reg_idx_t wreg_index;
        excp_e    excp;
    } id_ctrl_t;

    // bubble, no side effects
    localparam id_ctrl_t ctrl_nop = '{
        alu_op:     ALU_ADD,
        mem_op:     MEM_NONE,
        br_op:      BR_NONE,
        src1_sel:   SRC_REG,
        src2_sel:   SRC_REG,
        wreg_en:    1'b0,
        wreg_index: '0,
        excp:       EXCP_NONE
    };

endpackage

//--- logic/decode_if.sv
`timescale 1ns/1ps

interface decode_if import isa_pkg::*, pipe_pkg::*; ();

    id_ctrl_t  ctrl;
    imm_kind_e imm_kind;
    word_t     imm;
    // rd is read as second source (stores, conditional branches)
    logic      use_rd;

    modport producer (
        output ctrl,
        output imm_kind,
        output use_rd
    );

    modport imm_gen (
        input  imm_kind,
        output imm
    );

    modport consumer (
        input ctrl,
        input imm_kind,
        input imm,
        input use_rd
    );

endinterface

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  word_t             inst,
    input  logic              in_valid,
    output reg_idx_t          reg_index1,
    output reg_idx_t          reg_index2,
    decode_if.producer        dec
);

    logic [op_a_hi-op_a_lo:0] op_a;
    logic [op_b_hi-op_b_lo:0] op_b;
    logic [op_c_hi-op_c_lo:0] op_c;
    logic [op_d_hi-op_d_lo:0] op_d;
    reg_idx_t                 rd;
    reg_idx_t                 rj;
    reg_idx_t                 rk;
    id_ctrl_t                 ctrl;
    imm_kind_e                kind;
    logic                     use_rd;
    logic                     hit;

    assign op_a = inst[op_a_hi:op_a_lo];
    assign op_b = inst[op_b_hi:op_b_lo];
    assign op_c = inst[op_c_hi:op_c_lo];
    assign op_d = inst[op_d_hi:op_d_lo];
    assign rd   = inst[rd_lo +: reg_idx_w];
    assign rj   = inst[rj_lo +: reg_idx_w];
    assign rk   = inst[rk_lo +: reg_idx_w];

    always_comb begin
        ctrl            = ctrl_nop;
        ctrl.wreg_index = rd;
        kind            = IMM_NONE;
        use_rd          = 1'b0;
        hit             = 1'b0;
        case (op_a)
            6'h00: begin
                if (op_b == 4'h0 && op_c == 2'h1) begin
                    // three-register alu group
                    hit          = 1'b1;
                    ctrl.wreg_en = 1'b1;
                    case (op_d)
                        5'h00:   ctrl.alu_op = ALU_ADD;
                        5'h02:   ctrl.alu_op = ALU_SUB;
                        5'h04:   ctrl.alu_op = ALU_SLT;
                        5'h05:   ctrl.alu_op = ALU_SLTU;
                        5'h08:   ctrl.alu_op = ALU_NOR;
                        5'h09:   ctrl.alu_op = ALU_AND;
                        5'h0a:   ctrl.alu_op = ALU_OR;
                        5'h0b:   ctrl.alu_op = ALU_XOR;
                        5'h0e:   ctrl.alu_op = ALU_SLL;
                        5'h0f:   ctrl.alu_op = ALU_SRL;
                        5'h10:   ctrl.alu_op = ALU_SRA;
                        default: hit = 1'b0;
                    endcase
                end else if (op_b == 4'h0 && op_c == 2'h2) begin
                    hit = 1'b1;
                    case (op_d)
                        5'h14:   ctrl.excp = EXCP_BRK;
                        5'h16:   ctrl.excp = EXCP_SYS;
                        default: hit = 1'b0;
                    endcase
                end else if (op_b == 4'h1 && op_c == 2'h0) begin
                    // shift by ui5
                    hit           = 1'b1;
                    ctrl.wreg_en  = 1'b1;
                    ctrl.src2_sel = SRC_IMM;
                    kind          = IMM_UI5;
                    case (op_d)
                        5'h01:   ctrl.alu_op = ALU_SLL;
                        5'h09:   ctrl.alu_op = ALU_SRL;
                        5'h11:   ctrl.alu_op = ALU_SRA;
                        default: hit = 1'b0;
                    endcase
                end else begin
                    // 12-bit immediate group, logic ops zero extend
                    hit           = 1'b1;
                    ctrl.wreg_en  = 1'b1;
                    ctrl.src2_sel = SRC_IMM;
                    kind          = IMM_SI12;
                    case (op_b)
                        4'h8: ctrl.alu_op = ALU_SLT;
                        4'h9: ctrl.alu_op = ALU_SLTU;
                        4'ha: ctrl.alu_op = ALU_ADD;
                        4'hd: begin
                            ctrl.alu_op = ALU_AND;
                            kind        = IMM_UI12;
                        end
                        4'he: begin
                            ctrl.alu_op = ALU_OR;
                            kind        = IMM_UI12;
                        end
                        4'hf: begin
                            ctrl.alu_op = ALU_XOR;
                            kind        = IMM_UI12;
                        end
                        default: hit = 1'b0;
                    endcase
                end
            end
            6'h05, 6'h07: begin
                // lu12i / pcaddu12i, bit 25 must be clear
                hit           = !inst[op_b_hi];
                ctrl.wreg_en  = 1'b1;
                ctrl.src1_sel = SRC_IMM;
                kind          = IMM_UI20_HI;
                if (op_a == 6'h05) begin
                    ctrl.alu_op = ALU_LUI;
                end else begin
                    ctrl.src2_sel = SRC_PC;
                end
            end
            6'h0a: begin
                hit           = 1'b1;
                ctrl.src2_sel = SRC_IMM;
                kind          = IMM_SI12;
                case (op_b)
                    4'h0: ctrl.mem_op = MEM_LD_B;
                    4'h1: ctrl.mem_op = MEM_LD_H;
                    4'h2: ctrl.mem_op = MEM_LD_W;
                    4'h4: begin
                        ctrl.mem_op = MEM_ST_B;
                        use_rd      = 1'b1;
                    end
                    4'h5: begin
                        ctrl.mem_op = MEM_ST_H;
                        use_rd      = 1'b1;
                    end
                    4'h6: begin
                        ctrl.mem_op = MEM_ST_W;
                        use_rd      = 1'b1;
                    end
                    4'h8: ctrl.mem_op = MEM_LD_BU;
                    4'h9: ctrl.mem_op = MEM_LD_HU;
                    default: hit = 1'b0;
                endcase
                // only loads write back
                ctrl.wreg_en = !use_rd;
            end
            6'h13: begin
                hit           = 1'b1;
                ctrl.br_op    = BR_JIRL;
                ctrl.wreg_en  = 1'b1;
                ctrl.src2_sel = SRC_IMM;
                kind          = IMM_SI16_SH2;
            end
            6'h14, 6'h15: begin
                hit           = 1'b1;
                ctrl.src1_sel = SRC_PC;
                ctrl.src2_sel = SRC_IMM;
                kind          = IMM_SI26_SH2;
                if (op_a == 6'h15) begin
                    ctrl.br_op      = BR_BL;
                    ctrl.wreg_en    = 1'b1;
                    ctrl.wreg_index = ra_index;
                end else begin
                    ctrl.br_op = BR_B;
                end
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                // conditional branches compare rj with rd
                hit           = 1'b1;
                ctrl.src1_sel = SRC_PC;
                ctrl.src2_sel = SRC_IMM;
                kind          = IMM_SI16_SH2;
                use_rd        = 1'b1;
                case (op_a)
                    6'h16:   ctrl.br_op = BR_BEQ;
                    6'h17:   ctrl.br_op = BR_BNE;
                    6'h18:   ctrl.br_op = BR_BLT;
                    6'h19:   ctrl.br_op = BR_BGE;
                    6'h1a:   ctrl.br_op = BR_BLTU;
                    default: ctrl.br_op = BR_BGEU;
                endcase
            end
            default: hit = 1'b0;
        endcase

        // anything unmatched becomes a bubble carrying ine
        if (!hit) begin
            ctrl   = ctrl_nop;
            kind   = IMM_NONE;
            use_rd = 1'b0;
            if (in_valid) begin
                ctrl.excp = EXCP_INE;
            end
        end

        a_one_class: assert (ctrl.mem_op == MEM_NONE || ctrl.br_op == BR_NONE)
            else $error("decoder flagged both a memory and a branch op");
    end

    assign reg_index1   = rj;
    assign reg_index2   = use_rd ? rd : rk;
    assign dec.ctrl     = ctrl;
    assign dec.imm_kind = kind;
    assign dec.use_rd   = use_rd;

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import isa_pkg::*; (
    input  word_t     inst,
    decode_if.imm_gen dec
);

    logic [11:0]          i12;
    logic [15:0]          i16;
    logic [25:0]          i26;
    logic [19:0]          i20;
    logic [reg_idx_w-1:0] i5;

    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    // offs[15:0] sits above offs[25:16] in the encoding
    assign i26 = {inst[9:0], inst[25:10]};
    assign i20 = inst[24:5];
    assign i5  = inst[rk_lo +: reg_idx_w];

    always_comb begin
        case (dec.imm_kind)
            IMM_SI12:     dec.imm = {{20{i12[11]}}, i12};
            IMM_UI12:     dec.imm = {20'h0, i12};
            // branch offsets are word aligned
            IMM_SI16_SH2: dec.imm = {{14{i16[15]}}, i16, 2'b00};
            IMM_SI26_SH2: dec.imm = {{4{i26[25]}}, i26, 2'b00};
            IMM_UI20_HI:  dec.imm = {i20, 12'h000};
            IMM_UI5:      dec.imm = {{(xlen-reg_idx_w){1'b0}}, i5};
            default:      dec.imm = '0;
        endcase
    end

endmodule

//--- logic/id_stage_reg.sv
`timescale 1ns/1ps

module id_stage_reg import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      pc,
    input  logic       in_valid,
    output logic       in_ready,
    input  reg_idx_t   reg_index1,
    input  reg_idx_t   reg_index2,
    input  word_t      reg_data1,
    input  word_t      reg_data2,
    input  logic       ex_load_valid,
    input  reg_idx_t   ex_load_wreg,
    input  logic       flush,
    decode_if.consumer dec,
    output logic       out_valid,
    input  logic       out_ready,
    output id_ctrl_t   out_ctrl,
    output word_t      out_imm,
    output word_t      out_pc,
    output word_t      out_src1,
    output word_t      out_src2
);

    logic stall;
    logic accept;

    // load in execute targets one of our sources, r0 included
    assign stall = ex_load_valid &&
                   (ex_load_wreg == reg_index1 || ex_load_wreg == reg_index2);

    assign in_ready = !flush && !stall && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_ctrl <= ctrl_nop;
        end else if (accept) begin
            out_ctrl <= dec.ctrl;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (accept) begin
            out_imm  <= dec.imm;
            out_pc   <= pc;
            out_src1 <= reg_data1;
            out_src2 <= reg_data2;
        end
    end

    a_empty_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("stage not empty after reset");

    // held bundle must not move while execute stalls us
    a_hold_on_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_ctrl))
        else $error("output changed under back-pressure");

endmodule

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    inst,
    input  word_t    pc,
    input  logic     in_valid,
    output logic     in_ready,
    output reg_idx_t reg_index1,
    output reg_idx_t reg_index2,
    input  word_t    reg_data1,
    input  word_t    reg_data2,
    input  logic     ex_load_valid,
    input  reg_idx_t ex_load_wreg,
    input  logic     flush,
    output logic     out_valid,
    input  logic     out_ready,
    output id_ctrl_t out_ctrl,
    output word_t    out_imm,
    output word_t    out_pc,
    output word_t    out_src1,
    output word_t    out_src2
);

    decode_if dec_bus ();

    inst_decoder u_decoder (
        .inst       (inst),
        .in_valid   (in_valid),
        .reg_index1 (reg_index1),
        .reg_index2 (reg_index2),
        .dec        (dec_bus.producer)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .dec  (dec_bus.imm_gen)
    );

    // the register also sees the read indices for the hazard compare
    id_stage_reg u_stage_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc            (pc),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .reg_index1    (reg_index1),
        .reg_index2    (reg_index2),
        .reg_data1     (reg_data1),
        .reg_data2     (reg_data2),
        .ex_load_valid (ex_load_valid),
        .ex_load_wreg  (ex_load_wreg),
        .flush         (flush),
        .dec           (dec_bus.consumer),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_ctrl      (out_ctrl),
        .out_imm       (out_imm),
        .out_pc        (out_pc),
        .out_src1      (out_src1),
        .out_src2      (out_src2)
    );

endmodule

//--- dv/id_checks.svh
`ifndef ID_CHECKS_SVH
`define ID_CHECKS_SVH

// wrong values seen on DUT outputs
int value_errs = 0;
// protocol and flow problems
int other_errs = 0;

task automatic check_ctrl(input id_ctrl_t exp, input id_ctrl_t got, input string what);
    if (got !== exp) begin
        value_errs++;
        $display("CHECK FAILED at %0t: %s expected alu %s mem %s br %s wen %b wreg %0d excp %s",
                 $time, what, exp.alu_op.name(), exp.mem_op.name(), exp.br_op.name(),
                 exp.wreg_en, exp.wreg_index, exp.excp.name());
        $display("    got alu %s mem %s br %s wen %b wreg %0d excp %s (raw %h vs %h)",
                 got.alu_op.name(), got.mem_op.name(), got.br_op.name(),
                 got.wreg_en, got.wreg_index, got.excp.name(), got, exp);
    end
endtask

task automatic check_word(input word_t exp, input word_t got, input string what);
    if (got !== exp) begin
        value_errs++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
    end
endtask

task automatic check_index(input reg_idx_t exp, input reg_idx_t got, input string what);
    if (got !== exp) begin
        value_errs++;
        $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
endtask

`endif

//--- dv/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb import isa_pkg::*, pipe_pkg::*; ();

    `include "id_checks.svh"

    typedef struct packed {
        id_ctrl_t ctrl;
        word_t    imm;
        word_t    pc;
        word_t    src1;
        word_t    src2;
    } expect_t;

    localparam int max_lines = 64;
    localparam int n_cols    = 17;
    // this line is flushed once and then sent again
    localparam int flush_at  = 6;

    logic     clk = 1'b0;
    logic     rst_n;
    word_t    inst;
    word_t    pc;
    logic     in_valid;
    logic     in_ready;
    reg_idx_t reg_index1;
    reg_idx_t reg_index2;
    word_t    reg_data1;
    word_t    reg_data2;
    logic     ex_load_valid;
    reg_idx_t ex_load_wreg;
    logic     flush;
    logic     out_valid;
    logic     out_ready;
    id_ctrl_t out_ctrl;
    word_t    out_imm;
    word_t    out_pc;
    word_t    out_src1;
    word_t    out_src2;

    word_t   gold [max_lines][n_cols];
    expect_t exp_q [$];
    expect_t got_exp;
    int      n_lines = 0;
    int      n_out = 0;
    int      cycles = 0;
    int      limit = 0;
    logic    hold_ready = 1'b0;

    id_stage dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst          (inst),
        .pc            (pc),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .reg_index1    (reg_index1),
        .reg_index2    (reg_index2),
        .reg_data1     (reg_data1),
        .reg_data2     (reg_data2),
        .ex_load_valid (ex_load_valid),
        .ex_load_wreg  (ex_load_wreg),
        .flush         (flush),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_ctrl      (out_ctrl),
        .out_imm       (out_imm),
        .out_pc        (out_pc),
        .out_src1      (out_src1),
        .out_src2      (out_src2)
    );

    always #20 clk = ~clk;

    task automatic load_golden(output int count);
        int    fd;
        int    rc;
        string line;
        word_t v [n_cols];
        count = 0;
        fd = $fopen("dv/id_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && count < max_lines) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 0 && line[0] != "#") begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                                 v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
                    if (rc == n_cols) begin
                        for (int c = 0; c < n_cols; c++) begin
                            gold[count][c] = v[c];
                        end
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // expected bundle from columns 8 to 16 of a golden line
    function automatic expect_t golden_bundle(input int n);
        expect_t e;
        e.ctrl.alu_op     = alu_op_e'(gold[n][8][3:0]);
        e.ctrl.mem_op     = mem_op_e'(gold[n][9][3:0]);
        e.ctrl.br_op      = br_op_e'(gold[n][10][3:0]);
        e.ctrl.src1_sel   = src_sel_e'(gold[n][11][1:0]);
        e.ctrl.src2_sel   = src_sel_e'(gold[n][12][1:0]);
        e.ctrl.wreg_en    = gold[n][13][0];
        e.ctrl.wreg_index = gold[n][14][reg_idx_w-1:0];
        e.ctrl.excp       = excp_e'(gold[n][15][1:0]);
        e.imm             = gold[n][16];
        e.pc              = gold[n][1];
        e.src1            = gold[n][2];
        e.src2            = gold[n][3];
        return e;
    endfunction

    task automatic send_line(input int n);
        logic got;
        @(negedge clk);
        inst          = gold[n][0];
        pc            = gold[n][1];
        reg_data1     = gold[n][2];
        reg_data2     = gold[n][3];
        ex_load_valid = gold[n][4][0];
        ex_load_wreg  = gold[n][5][reg_idx_w-1:0];
        in_valid      = 1'b1;
        if (ex_load_valid) begin
            @(posedge clk);
            if (in_ready) begin
                other_errs++;
                $display("in_ready was high during a load-use hazard at %0t", $time);
            end
            @(negedge clk);
            ex_load_valid = 1'b0;
        end
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            got = in_ready;
        end
        check_index(gold[n][6][reg_idx_w-1:0], reg_index1, "reg_index1");
        check_index(gold[n][7][reg_idx_w-1:0], reg_index2, "reg_index2");
        exp_q.push_back(golden_bundle(n));
    endtask

    // drop the instruction just accepted while execute holds it
    task automatic flush_held();
        hold_ready = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        flush    = 1'b1;
        @(posedge clk);
        void'(exp_q.pop_back());
        hold_ready = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        if (out_valid) begin
            other_errs++;
            $display("flush did not clear out_valid at %0t", $time);
        end
    endtask

    always @(negedge clk) begin
        out_ready = !hold_ready && ($urandom % 4 != 0);
    end

    // scoreboard
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("output transfer at %0t with no instruction expected", $time);
            end else begin
                got_exp = exp_q.pop_front();
                check_ctrl(got_exp.ctrl, out_ctrl, "out_ctrl");
                check_word(got_exp.imm, out_imm, "out_imm");
                check_word(got_exp.pc, out_pc, "out_pc");
                check_word(got_exp.src1, out_src1, "out_src1");
                check_word(got_exp.src2, out_src2, "out_src2");
            end
            n_out++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: outputs stopped");
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic flushed;
        void'($urandom(32'h4ae6));
        rst_n         = 1'b0;
        inst          = '0;
        pc            = '0;
        in_valid      = 1'b0;
        reg_data1     = '0;
        reg_data2     = '0;
        ex_load_valid = 1'b0;
        ex_load_wreg  = '0;
        flush         = 1'b0;
        out_ready     = 1'b0;
        flushed       = 1'b0;
        load_golden(n_lines);
        if (n_lines == 0) begin
            $display("golden file missing or empty");
            $display("Verification failed");
            $finish;
        end else begin
            limit = 8 * n_lines + 20;
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < n_lines; i++) begin
                send_line(i);
                if (i == flush_at && !flushed) begin
                    flushed = 1'b1;
                    flush_held();
                    i--;
                end
            end
            @(negedge clk);
            in_valid = 1'b0;
            while (n_out < n_lines) begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);
            if (exp_q.size() != 0 || n_out != n_lines) begin
                other_errs++;
                $display("instructions lost or repeated, %0d delivered", n_out);
            end
            $display("errors: %0d wrong values, %0d other", value_errs, other_errs);
            if (value_errs == 0 && other_errs == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

//--- dv/id_golden.txt
# inst pc rdata1 rdata2 ld_valid ld_wreg | idx1 idx2 alu mem br src1 src2 wen wreg excp imm
# all hex, enum columns hold the encoded enum value
00101483 1c000000 a5a50000 5a5a0000 0 00 04 05 0 0 0 0 0 1 03 0 00000000
00111483 1c000004 a5a50001 5a5a0001 1 04 04 05 1 0 0 0 0 1 03 0 00000000
00129483 1c000008 a5a50002 5a5a0002 0 00 04 05 3 0 0 0 0 1 03 0 00000000
00141483 1c00000c a5a50003 5a5a0003 0 00 04 05 6 0 0 0 0 1 03 0 00000000
00181483 1c000010 a5a50004 5a5a0004 0 00 04 05 a 0 0 0 0 1 03 0 00000000
00409c83 1c000014 a5a50005 5a5a0005 0 00 04 07 8 0 0 0 1 1 03 0 00000007
0048fc83 1c000018 a5a50006 5a5a0006 0 00 04 1f a 0 0 0 1 1 03 0 0000001f
02bffc83 1c00001c a5a50007 5a5a0007 0 00 04 1f 0 0 0 0 1 1 03 0 ffffffff
03600083 1c000020 a5a50008 5a5a0008 0 00 04 00 4 0 0 0 1 1 03 0 00000800
02200083 1c000024 a5a50009 5a5a0009 0 00 04 00 2 0 0 0 1 1 03 0 fffff800
142468a3 1c000028 a5a5000a 5a5a000a 0 00 05 1a b 0 0 1 0 1 03 0 12345000
1c000023 1c00002c a5a5000b 5a5a000b 0 00 01 00 0 0 0 1 2 1 03 0 00001000
28802083 1c000030 a5a5000c 5a5a000c 0 00 04 08 0 3 0 0 1 1 03 0 00000008
2a3ff083 1c000034 a5a5000d 5a5a000d 0 00 04 1c 0 4 0 0 1 1 03 0 fffffffc
29400883 1c000038 a5a5000e 5a5a000e 1 03 04 03 0 7 0 0 1 0 03 0 00000002
29800083 1c00003c a5a5000f 5a5a000f 0 00 04 03 0 8 0 0 1 0 03 0 00000000
4c001083 1c000040 a5a50010 5a5a0010 0 00 04 04 0 0 1 0 1 1 03 0 00000010
53fffbff 1c000044 a5a50011 5a5a0011 0 00 1f 1e 0 0 2 2 1 0 1f 0 fffffff8
54040000 1c000048 a5a50012 5a5a0012 0 00 00 00 0 0 3 2 1 1 01 0 00000400
5bfffc83 1c00004c a5a50013 5a5a0013 0 00 04 03 0 0 4 2 1 0 03 0 fffffffc
6c002083 1c000050 a5a50014 5a5a0014 0 00 04 03 0 0 9 2 1 0 03 0 00000020
002b0000 1c000054 a5a50015 5a5a0015 0 00 00 00 0 0 0 0 0 0 00 1 00000000
002a0005 1c000058 a5a50016 5a5a0016 0 00 00 00 0 0 0 0 0 0 05 2 00000000
fc000000 1c00005c a5a50017 5a5a0017 0 00 00 00 0 0 0 0 0 0 00 3 00000000

//--- list.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_if.sv
logic/inst_decoder.sv
logic/imm_gen.sv
logic/id_stage_reg.sv
logic/id_stage.sv
+incdir+dv
dv/id_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the decode-stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module id_stage_tb -Mdir obj_dir \
    && ./obj_dir/Vid_stage_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Verification passed" sim.log && ! grep -q "Verification failed" sim.log
